//--- common/dp_pkg.sv
//----------------------------------------
// Shared widths, opcode and operation
// enums, and the pipeline stage records.
//----------------------------------------

package dp_pkg;

    localparam int unsigned XLEN       = 64;
    localparam int unsigned INSTR_W    = 32;
    localparam int unsigned REG_ADDR_W = 5;

    // Major opcodes of the supported RV64I subset.
    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_AND    = 4'd2,
        ALU_OR     = 4'd3,
        ALU_XOR    = 4'd4,
        ALU_SLT    = 4'd5,
        ALU_SLL    = 4'd6,
        ALU_SRL    = 4'd7,
        ALU_PASS_B = 4'd8
    } alu_op_e;

    // Encoded as the func3 field of the branch instruction.
    typedef enum logic [2:0] {
        BR_EQ = 3'b000,
        BR_NE = 3'b001,
        BR_LT = 3'b100,
        BR_GE = 3'b101
    } branch_op_e;

    //----------------------------------------
    // Stage records.
    //----------------------------------------

    typedef struct packed {
        logic                 valid;
        logic [XLEN-1:0]      pc;
        logic [INSTR_W-1:0]   instr;
    } issue_t;

    typedef struct packed {
        logic                  valid;
        logic [XLEN-1:0]       pc;
        logic [REG_ADDR_W-1:0] rs1_addr;
        logic [REG_ADDR_W-1:0] rs2_addr;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       rs1_data;
        logic [XLEN-1:0]       rs2_data;
        logic [XLEN-1:0]       imm;
        alu_op_e               alu_op;
        logic                  alu_src_imm;
        logic                  reg_we;
        logic                  is_branch;
        branch_op_e            branch_op;
        logic                  is_jump;
    } exec_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_we;
        logic [REG_ADDR_W-1:0] rd_addr;
        logic [XLEN-1:0]       data;
        logic                  redirect;
        logic [XLEN-1:0]       target;
    } retire_t;

endpackage

//--- execute/alu.sv
//----------------------------------------
// 64-bit integer ALU.
//----------------------------------------

`timescale 1ns/10ps

module alu (
    input  dp_pkg::alu_op_e          i_op,
    input  logic [dp_pkg::XLEN-1:0]  i_a,
    input  logic [dp_pkg::XLEN-1:0]  i_b,
    output logic [dp_pkg::XLEN-1:0]  o_result
);

    logic [5:0] shamt;
    logic       lt_signed;

    // RV64 shifts take six bits of shift amount.
    assign shamt     = i_b[5:0];
    assign lt_signed = $signed(i_a) < $signed(i_b);

    always_comb begin
        case (i_op)
            dp_pkg::ALU_ADD:    o_result = i_a + i_b;
            dp_pkg::ALU_SUB:    o_result = i_a - i_b;
            dp_pkg::ALU_AND:    o_result = i_a & i_b;
            dp_pkg::ALU_OR:     o_result = i_a | i_b;
            dp_pkg::ALU_XOR:    o_result = i_a ^ i_b;
            dp_pkg::ALU_SLT:    o_result = {{(dp_pkg::XLEN-1){1'b0}}, lt_signed};
            dp_pkg::ALU_SLL:    o_result = i_a << shamt;
            dp_pkg::ALU_SRL:    o_result = i_a >> shamt;
            // LUI result is the immediate.
            dp_pkg::ALU_PASS_B: o_result = i_b;
            default:            o_result = '0;
        endcase
    end

endmodule

//--- execute/branch_unit.sv
//----------------------------------------
// Branch compare, target and link address.
//----------------------------------------

`timescale 1ns/10ps

module branch_unit (
    input  logic                     i_is_branch,
    input  logic                     i_is_jump,
    input  dp_pkg::branch_op_e       i_op,
    input  logic [dp_pkg::XLEN-1:0]  i_pc,
    input  logic [dp_pkg::XLEN-1:0]  i_rs1,
    input  logic [dp_pkg::XLEN-1:0]  i_rs2,
    input  logic [dp_pkg::XLEN-1:0]  i_imm,
    output logic                     o_taken,
    output logic [dp_pkg::XLEN-1:0]  o_target,
    output logic [dp_pkg::XLEN-1:0]  o_link
);

    logic cond;

    // LT and GE compare signed.
    always_comb begin
        case (i_op)
            dp_pkg::BR_EQ: cond = (i_rs1 == i_rs2);
            dp_pkg::BR_NE: cond = (i_rs1 != i_rs2);
            dp_pkg::BR_LT: cond = ($signed(i_rs1) <  $signed(i_rs2));
            dp_pkg::BR_GE: cond = ($signed(i_rs1) >= $signed(i_rs2));
            default:       cond = 1'b0;
        endcase
    end

    assign o_taken  = i_is_jump || (i_is_branch && cond);
    assign o_target = i_pc + i_imm;
    assign o_link   = i_pc + 64'd4;

endmodule

//--- execute/execute_stage.sv
//----------------------------------------
// Operand forwarding, ALU and branch unit,
// retire record and writeback register.
//----------------------------------------

`timescale 1ns/10ps

module execute_stage (
    input  logic             i_clk,
    input  logic             i_arst,
    input  dp_pkg::exec_t    i_exec,
    input  logic             i_stall,
    output logic             o_flush,
    output dp_pkg::retire_t  o_retire
);

    dp_pkg::retire_t         wb_q;
    dp_pkg::retire_t         retire_d;
    logic                    fwd_rs1;
    logic                    fwd_rs2;
    logic [dp_pkg::XLEN-1:0] rs1_val;
    logic [dp_pkg::XLEN-1:0] rs2_val;
    logic [dp_pkg::XLEN-1:0] alu_b;
    logic [dp_pkg::XLEN-1:0] alu_result;
    logic [dp_pkg::XLEN-1:0] br_target;
    logic [dp_pkg::XLEN-1:0] br_link;
    logic                    br_taken;

    //----------------------------------------
    // Forwarding from the writeback register.
    //----------------------------------------

    assign fwd_rs1 = wb_q.valid && wb_q.reg_we && (wb_q.rd_addr != '0) &&
                     (wb_q.rd_addr == i_exec.rs1_addr);
    assign fwd_rs2 = wb_q.valid && wb_q.reg_we && (wb_q.rd_addr != '0) &&
                     (wb_q.rd_addr == i_exec.rs2_addr);

    assign rs1_val = fwd_rs1 ? wb_q.data : i_exec.rs1_data;
    assign rs2_val = fwd_rs2 ? wb_q.data : i_exec.rs2_data;
    assign alu_b   = i_exec.alu_src_imm ? i_exec.imm : rs2_val;

    alu alu_inst (
        .i_op     ( i_exec.alu_op ),
        .i_a      ( rs1_val       ),
        .i_b      ( alu_b         ),
        .o_result ( alu_result    )
    );

    branch_unit branch_unit_inst (
        .i_is_branch ( i_exec.valid && i_exec.is_branch ),
        .i_is_jump   ( i_exec.valid && i_exec.is_jump   ),
        .i_op        ( i_exec.branch_op                 ),
        .i_pc        ( i_exec.pc                        ),
        .i_rs1       ( rs1_val                          ),
        .i_rs2       ( rs2_val                          ),
        .i_imm       ( i_exec.imm                       ),
        .o_taken     ( br_taken                         ),
        .o_target    ( br_target                        ),
        .o_link      ( br_link                          )
    );

    //----------------------------------------
    // Retire record and writeback register.
    //----------------------------------------

    always_comb begin
        retire_d.valid    = i_exec.valid;
        retire_d.reg_we   = i_exec.valid && i_exec.reg_we;
        retire_d.rd_addr  = i_exec.rd_addr;
        retire_d.data     = i_exec.is_jump ? br_link : alu_result;
        retire_d.redirect = br_taken;
        retire_d.target   = br_target;
    end

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            wb_q <= '0;
        end else if (!i_stall) begin
            wb_q <= retire_d;
        end
    end

    // Squash the younger instruction in decode.
    assign o_flush  = br_taken;
    assign o_retire = wb_q;

    // Every redirect was launched by a valid branch or jump in execute.
    assert property (@(posedge i_clk) disable iff (i_arst)
        $rose(o_retire.redirect) |->
            $past(i_exec.valid && (i_exec.is_branch || i_exec.is_jump) && !i_stall));

endmodule

//--- decode/register_file.sv
//----------------------------------------
// 32 x 64-bit register file, x0 reads zero,
// write-through bypass to both read ports.
//----------------------------------------

`timescale 1ns/10ps

module register_file (
    input  logic                          i_clk,
    input  logic                          i_arst,
    input  logic                          i_stall,
    input  dp_pkg::retire_t               i_write,
    input  logic [dp_pkg::REG_ADDR_W-1:0] i_rs1_addr,
    input  logic [dp_pkg::REG_ADDR_W-1:0] i_rs2_addr,
    output logic [dp_pkg::XLEN-1:0]       o_rs1_data,
    output logic [dp_pkg::XLEN-1:0]       o_rs2_data
);

    logic [dp_pkg::XLEN-1:0] regs [32];
    logic                    wr_pending;

    // A retiring write, whether or not this edge commits it.
    assign wr_pending = i_write.valid && i_write.reg_we;

    always_ff @(posedge i_clk) begin
        if (wr_pending && !i_stall && (i_write.rd_addr != '0)) begin
            regs[i_write.rd_addr] <= i_write.data;
        end
    end

    // Read ports, with bypass of the pending write.
    always_comb begin
        if (i_rs1_addr == '0) begin
            o_rs1_data = '0;
        end else if (wr_pending && (i_write.rd_addr == i_rs1_addr)) begin
            o_rs1_data = i_write.data;
        end else begin
            o_rs1_data = regs[i_rs1_addr];
        end

        if (i_rs2_addr == '0) begin
            o_rs2_data = '0;
        end else if (wr_pending && (i_write.rd_addr == i_rs2_addr)) begin
            o_rs2_data = i_write.data;
        end else begin
            o_rs2_data = regs[i_rs2_addr];
        end
    end

    // Decode clears the write enable for x0 destinations.
    assert property (@(posedge i_clk) disable iff (i_arst)
        wr_pending |-> (i_write.rd_addr != '0));

endmodule

//--- decode/decode_stage.sv
//----------------------------------------
// Decode register, instruction decoder with
// immediates, register file, execute register.
//----------------------------------------

`timescale 1ns/10ps

module decode_stage (
    input  logic             i_clk,
    input  logic             i_arst,
    input  dp_pkg::issue_t   i_issue,
    input  logic             i_stall,
    input  logic             i_flush,
    input  dp_pkg::retire_t  i_retire,
    output dp_pkg::exec_t    o_exec
);

    dp_pkg::issue_t              dec_q;
    dp_pkg::exec_t               exec_d;
    dp_pkg::exec_t               exec_q;
    logic [dp_pkg::INSTR_W-1:0]  instr;
    dp_pkg::opcode_e             opcode;
    logic [2:0]                  func3;
    logic                        func7_5;
    logic                        legal;
    logic [dp_pkg::XLEN-1:0]     imm_i;
    logic [dp_pkg::XLEN-1:0]     imm_u;
    logic [dp_pkg::XLEN-1:0]     imm_b;
    logic [dp_pkg::XLEN-1:0]     imm_j;
    logic [dp_pkg::XLEN-1:0]     rs1_data;
    logic [dp_pkg::XLEN-1:0]     rs2_data;

    //----------------------------------------
    // Field extraction and immediates.
    //----------------------------------------

    assign instr   = dec_q.instr;
    assign opcode  = dp_pkg::opcode_e'(instr[6:0]);
    assign func3   = instr[14:12];
    assign func7_5 = instr[30];

    assign imm_i = {{52{instr[31]}}, instr[31:20]};
    assign imm_u = {{32{instr[31]}}, instr[31:12], 12'b0};
    assign imm_b = {{51{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
    assign imm_j = {{43{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

    register_file register_file_inst (
        .i_clk      ( i_clk              ),
        .i_arst     ( i_arst             ),
        .i_stall    ( i_stall            ),
        .i_write    ( i_retire           ),
        .i_rs1_addr ( instr[19:15]       ),
        .i_rs2_addr ( instr[24:20]       ),
        .o_rs1_data ( rs1_data           ),
        .o_rs2_data ( rs2_data           )
    );

    //----------------------------------------
    // Control decode.
    //----------------------------------------

    always_comb begin
        exec_d           = '0;
        legal            = 1'b0;
        exec_d.pc        = dec_q.pc;
        exec_d.rs1_addr  = instr[19:15];
        exec_d.rs2_addr  = instr[24:20];
        exec_d.rd_addr   = instr[11:7];
        exec_d.rs1_data  = rs1_data;
        exec_d.rs2_data  = rs2_data;
        exec_d.alu_op    = dp_pkg::ALU_ADD;
        exec_d.branch_op = dp_pkg::branch_op_e'(func3);

        case (opcode)
            dp_pkg::OPC_OP: begin
                legal         = 1'b1;
                exec_d.reg_we = 1'b1;
                case (func3)
                    3'b000:  exec_d.alu_op = func7_5 ? dp_pkg::ALU_SUB : dp_pkg::ALU_ADD;
                    3'b001:  exec_d.alu_op = dp_pkg::ALU_SLL;
                    3'b010:  exec_d.alu_op = dp_pkg::ALU_SLT;
                    3'b100:  exec_d.alu_op = dp_pkg::ALU_XOR;
                    3'b110:  exec_d.alu_op = dp_pkg::ALU_OR;
                    3'b111:  exec_d.alu_op = dp_pkg::ALU_AND;
                    // SRA shares func3 with SRL and is not supported.
                    3'b101: begin
                        exec_d.alu_op = dp_pkg::ALU_SRL;
                        legal         = !func7_5;
                    end
                    default: legal = 1'b0;
                endcase
            end
            dp_pkg::OPC_OP_IMM: begin
                // Only ADDI.
                legal              = (func3 == 3'b000);
                exec_d.alu_src_imm = 1'b1;
                exec_d.imm         = imm_i;
                exec_d.reg_we      = 1'b1;
            end
            dp_pkg::OPC_LUI: begin
                legal              = 1'b1;
                exec_d.alu_op      = dp_pkg::ALU_PASS_B;
                exec_d.alu_src_imm = 1'b1;
                exec_d.imm         = imm_u;
                exec_d.reg_we      = 1'b1;
            end
            dp_pkg::OPC_BRANCH: begin
                legal            = (func3 == 3'b000) || (func3 == 3'b001) ||
                                   (func3 == 3'b100) || (func3 == 3'b101);
                exec_d.is_branch = 1'b1;
                exec_d.imm       = imm_b;
            end
            dp_pkg::OPC_JAL: begin
                legal          = 1'b1;
                exec_d.is_jump = 1'b1;
                exec_d.imm     = imm_j;
                exec_d.reg_we  = 1'b1;
            end
            default: legal = 1'b0;
        endcase

        // Writes to x0 are dropped here.
        if (exec_d.rd_addr == '0) begin
            exec_d.reg_we = 1'b0;
        end

        // Squashed or unknown instructions go on as bubbles.
        exec_d.valid = dec_q.valid && legal && !i_flush;
        if (!exec_d.valid) begin
            exec_d = '0;
        end
    end

    //----------------------------------------
    // Decode and execute registers.
    //----------------------------------------

    always_ff @(posedge i_clk or posedge i_arst) begin
        if (i_arst) begin
            dec_q  <= '0;
            exec_q <= '0;
        end else if (!i_stall) begin
            dec_q  <= i_issue;
            exec_q <= exec_d;
        end
    end

    assign o_exec = exec_q;

    // A redirect in writeback leaves a bubble in execute behind it.
    assert property (@(posedge i_clk) disable iff (i_arst)
        (i_retire.valid && i_retire.redirect) |-> !o_exec.valid);

endmodule

//--- verilog/datapath_top.sv
//----------------------------------------
// Top level of the integer pipeline.
// Connects the decode and execute stages.
//----------------------------------------

`timescale 1ns/10ps

module datapath_top (
    input  logic             i_clk,
    input  logic             i_arst,
    input  dp_pkg::issue_t   i_issue,
    input  logic             i_stall,
    output dp_pkg::retire_t  o_retire
);

    //----------------------------------------
    // Stage interconnect.
    //----------------------------------------

    dp_pkg::exec_t   exec;
    dp_pkg::retire_t retire;
    logic            flush;

    // Decode register, decoder, register file and execute register.
    decode_stage decode_stage_inst (
        .i_clk    ( i_clk    ),
        .i_arst   ( i_arst   ),
        .i_issue  ( i_issue  ),
        .i_stall  ( i_stall  ),
        .i_flush  ( flush    ),
        .i_retire ( retire   ),
        .o_exec   ( exec     )
    );

    // Forwarding, ALU, branch unit and writeback register.
    execute_stage execute_stage_inst (
        .i_clk    ( i_clk    ),
        .i_arst   ( i_arst   ),
        .i_exec   ( exec     ),
        .i_stall  ( i_stall  ),
        .o_flush  ( flush    ),
        .o_retire ( retire   )
    );

    // The writeback register is also the retire port.
    assign o_retire = retire;

endmodule

//--- tb/datapath_tb.sv
//----------------------------------------
// Testbench for the integer pipeline with an
// ISA reference model and directed tests.
//----------------------------------------

`timescale 1ns/10ps

module datapath_tb;

    logic                    i_clk;
    logic                    i_arst;
    dp_pkg::issue_t          issue;
    logic                    stall;
    dp_pkg::retire_t         retire;

    logic [31:0]             lfsr = 32'h837d_59fd;
    logic [dp_pkg::XLEN-1:0] mregs [32];
    logic [31:0]             prog [$];
    dp_pkg::retire_t         act_q [$];
    int                      edge_cnt = 0;
    int                      issued_total = 0;
    int                      errors = 0;
    int                      checks = 0;
    bit                      acc_seen;
    int                      first_acc_edge;
    int                      first_ret_edge;

    datapath_top datapath_top_inst (
        .i_clk    ( i_clk  ),
        .i_arst   ( i_arst ),
        .i_issue  ( issue  ),
        .i_stall  ( stall  ),
        .o_retire ( retire )
    );

    initial begin
        i_clk = 1'b0;
        forever #2 i_clk = ~i_clk;
    end

    always @(posedge i_clk) edge_cnt <= edge_cnt + 1;

    // Retire monitor. Values sampled mid-cycle are the ones seen by the next edge.
    always @(negedge i_clk) begin
        if (!i_arst) begin
            if (issue.valid && !stall && !acc_seen) begin
                acc_seen       = 1'b1;
                first_acc_edge = edge_cnt + 1;
            end
            if (retire.valid && !stall) begin
                if (act_q.size() == 0) begin
                    first_ret_edge = edge_cnt;
                end
                act_q.push_back(retire);
            end
        end
    end

    // The watchdog budget grows with every issued instruction.
    initial begin
        while (edge_cnt <= issued_total * 20 + 200) begin
            @(posedge i_clk);
        end
        $display("Timeout: the pipeline stopped making progress and the run was ended.");
        $display("TEST FAILED");
        $finish;
    end

    //----------------------------------------
    // Stimulus helpers.
    //----------------------------------------

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit.
    function automatic logic [63:0] rand_bits(input int n);
        logic [63:0] r;
        logic        fb;
        r = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            lfsr = {lfsr[30:0], fb};
            r    = {r[62:0], fb};
        end
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                          input logic [4:0] rs1, input logic [2:0] f3,
                                          input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic logic [31:0] enc_addi(input logic [11:0] imm, input logic [4:0] rs1,
                                             input logic [4:0] rd);
        return {imm, rs1, 3'b000, rd, 7'b0010011};
    endfunction

    function automatic logic [31:0] enc_lui(input logic [19:0] imm, input logic [4:0] rd);
        return {imm, rd, 7'b0110111};
    endfunction

    function automatic logic [31:0] enc_br(input logic [12:0] off, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] f3);
        return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], 7'b1100011};
    endfunction

    function automatic logic [31:0] enc_jal(input logic [20:0] off, input logic [4:0] rd);
        return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
    endfunction

    // ISA model of one instruction in program order.
    function automatic dp_pkg::retire_t model_step(input logic [63:0] pc,
                                                   input logic [31:0] ins);
        dp_pkg::retire_t r;
        logic [63:0]     a;
        logic [63:0]     b;
        logic [63:0]     imm;
        logic            cond;
        r         = '0;
        a         = mregs[ins[19:15]];
        b         = mregs[ins[24:20]];
        r.valid   = 1'b1;
        r.rd_addr = ins[11:7];
        case (ins[6:0])
            7'b0110011: begin
                r.reg_we = 1'b1;
                case (ins[14:12])
                    3'd0:    r.data = ins[30] ? a - b : a + b;
                    3'd1:    r.data = a << b[5:0];
                    3'd2:    r.data = {63'b0, $signed(a) < $signed(b)};
                    3'd4:    r.data = a ^ b;
                    3'd5:    r.data = a >> b[5:0];
                    3'd6:    r.data = a | b;
                    default: r.data = a & b;
                endcase
            end
            7'b0010011: begin
                r.reg_we = 1'b1;
                r.data   = a + {{52{ins[31]}}, ins[31:20]};
            end
            7'b0110111: begin
                r.reg_we = 1'b1;
                r.data   = {{32{ins[31]}}, ins[31:12], 12'h000};
            end
            7'b1100011: begin
                imm = {{51{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
                case (ins[14:12])
                    3'd0:    cond = (a == b);
                    3'd1:    cond = (a != b);
                    3'd4:    cond = ($signed(a) < $signed(b));
                    default: cond = ($signed(a) >= $signed(b));
                endcase
                r.redirect = cond;
                r.target   = pc + imm;
            end
            default: begin
                imm        = {{43{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
                r.reg_we   = 1'b1;
                r.data     = pc + 64'd4;
                r.redirect = 1'b1;
                r.target   = pc + imm;
            end
        endcase
        if (r.rd_addr == 5'd0) begin
            r.reg_we = 1'b0;
        end
        if (r.reg_we) begin
            mregs[r.rd_addr] = r.data;
        end
        return r;
    endfunction

    //----------------------------------------
    // Compare tasks.
    //----------------------------------------

    function automatic string retire_text(input dp_pkg::retire_t r);
        return $sformatf("valid %0b we %0b rd x%0d data %h redirect %0b target %h",
                         r.valid, r.reg_we, r.rd_addr, r.data, r.redirect, r.target);
    endfunction

    // Data and rd only matter with a write, target only with a redirect.
    task automatic check_retire(input string name, input dp_pkg::retire_t exp,
                                input dp_pkg::retire_t act);
        bit bad;
        checks++;
        bad = (exp.valid != act.valid) || (exp.reg_we != act.reg_we) ||
              (exp.redirect != act.redirect);
        if (exp.reg_we && ((exp.rd_addr != act.rd_addr) || (exp.data != act.data))) begin
            bad = 1'b1;
        end
        if (exp.redirect && (exp.target != act.target)) begin
            bad = 1'b1;
        end
        if (bad) begin
            errors++;
            $display("[FAIL] %s: expected %s, actual %s", name,
                     retire_text(exp), retire_text(act));
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("[FAIL] %s: expected %0d retires, actual %0d", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        checks++;
        if (exp != act) begin
            errors++;
            $display("[FAIL] %s: expected latency %0d edges, actual %0d", name, exp, act);
        end
    endtask

    // Issues the queued program, drains the pipeline and checks the retires.
    task automatic run_stream(input string name, input logic [63:0] base,
                              input bit stall_en, input bit check_lat);
        dp_pkg::retire_t exp_q [$];
        dp_pkg::retire_t r;
        logic [63:0]     rv;
        bit              skip;
        int              k;
        int              wait_cnt;
        skip = 1'b0;
        foreach (prog[i]) begin
            if (skip) begin
                skip = 1'b0;
            end else begin
                r = model_step(base + 64'(i) * 64'd4, prog[i]);
                exp_q.push_back(r);
                skip = r.redirect;
            end
        end
        act_q.delete();
        acc_seen     = 1'b0;
        issued_total = issued_total + prog.size();
        k            = 0;
        while (k < prog.size()) begin
            rv          = rand_bits(2);
            stall       = stall_en && (rv[1:0] == 2'b00);
            issue.valid = 1'b1;
            issue.pc    = base + 64'(k) * 64'd4;
            issue.instr = prog[k];
            @(posedge i_clk);
            if (!stall) begin
                k++;
            end
            #1;
        end
        issue    = '0;
        wait_cnt = 0;
        while ((act_q.size() < exp_q.size()) && (wait_cnt < 100)) begin
            rv    = rand_bits(2);
            stall = stall_en && (rv[1:0] == 2'b00);
            @(posedge i_clk);
            #1;
            wait_cnt++;
        end
        stall = 1'b0;
        repeat (4) @(posedge i_clk);
        #1;
        check_count(name, exp_q.size(), act_q.size());
        for (int i = 0; (i < exp_q.size()) && (i < act_q.size()); i++) begin
            check_retire($sformatf("%s[%0d]", name, i), exp_q[i], act_q[i]);
        end
        if (check_lat) begin
            check_latency(name, 2, first_ret_edge - first_acc_edge);
        end
        prog.delete();
    endtask

    //----------------------------------------
    // Directed tests.
    //----------------------------------------

    task automatic test_reset();
        dp_pkg::retire_t idle;
        idle = '0;
        repeat (10) begin
            @(negedge i_clk);
            check_retire("reset", idle, retire);
        end
        @(posedge i_clk);
        #1;
    endtask

    task automatic test_alu_ops();
        logic [63:0] hi;
        logic [63:0] lo;
        // Every register gets a known value first.
        for (int r = 1; r < 32; r++) begin
            hi = rand_bits(20);
            lo = rand_bits(12);
            prog.push_back(enc_lui(hi[19:0], 5'(r)));
            prog.push_back(enc_addi(lo[11:0], 5'(r), 5'(r)));
        end
        prog.push_back(enc_r(7'h00, 5'd2, 5'd1, 3'd0, 5'd20));
        prog.push_back(enc_r(7'h20, 5'd4, 5'd3, 3'd0, 5'd21));
        prog.push_back(enc_r(7'h00, 5'd6, 5'd5, 3'd7, 5'd22));
        prog.push_back(enc_r(7'h00, 5'd8, 5'd7, 3'd6, 5'd23));
        prog.push_back(enc_r(7'h00, 5'd3, 5'd1, 3'd4, 5'd24));
        prog.push_back(enc_r(7'h00, 5'd4, 5'd2, 3'd2, 5'd25));
        prog.push_back(enc_r(7'h00, 5'd2, 5'd4, 3'd2, 5'd26));
        prog.push_back(enc_r(7'h00, 5'd6, 5'd5, 3'd1, 5'd27));
        prog.push_back(enc_r(7'h00, 5'd8, 5'd7, 3'd5, 5'd28));
        prog.push_back(enc_addi(12'(-5), 5'd1, 5'd29));
        run_stream("alu_ops", 64'h1000, 1'b0, 1'b1);
    endtask

    task automatic test_dependencies();
        prog.push_back(enc_addi(12'd7, 5'd0, 5'd10));
        prog.push_back(enc_r(7'h00, 5'd10, 5'd10, 3'd0, 5'd11));
        prog.push_back(enc_r(7'h20, 5'd11, 5'd10, 3'd0, 5'd12));
        prog.push_back(enc_r(7'h00, 5'd10, 5'd12, 3'd4, 5'd13));
        prog.push_back(enc_addi(12'(-100), 5'd0, 5'd14));
        prog.push_back(enc_addi(12'd1, 5'd1, 5'd20));
        prog.push_back(enc_r(7'h00, 5'd13, 5'd14, 3'd2, 5'd15));
        prog.push_back(enc_addi(12'd3, 5'd0, 5'd16));
        prog.push_back(enc_addi(12'd1, 5'd2, 5'd21));
        prog.push_back(enc_addi(12'd1, 5'd3, 5'd22));
        prog.push_back(enc_r(7'h00, 5'd16, 5'd13, 3'd1, 5'd17));
        prog.push_back(enc_r(7'h00, 5'd16, 5'd17, 3'd5, 5'd18));
        run_stream("dependencies", 64'h2000, 1'b0, 1'b0);
    endtask

    // One taken and one not-taken branch, each followed by a marker.
    task automatic add_branch_case(input logic [2:0] f3, input logic [4:0] t1,
                                   input logic [4:0] t2, input logic [4:0] n1,
                                   input logic [4:0] n2);
        prog.push_back(enc_br(13'd16, t2, t1, f3));
        prog.push_back(enc_addi(12'd1, 5'd30, 5'd30));
        prog.push_back(enc_addi(12'd1, 5'd31, 5'd31));
        prog.push_back(enc_br(13'(-8), n2, n1, f3));
        prog.push_back(enc_addi(12'd1, 5'd30, 5'd30));
    endtask

    task automatic test_branches();
        prog.push_back(enc_addi(12'd5, 5'd0, 5'd1));
        prog.push_back(enc_addi(12'(-3), 5'd0, 5'd2));
        prog.push_back(enc_addi(12'd5, 5'd0, 5'd3));
        add_branch_case(3'd0, 5'd1, 5'd3, 5'd1, 5'd2);
        add_branch_case(3'd1, 5'd1, 5'd2, 5'd1, 5'd3);
        add_branch_case(3'd4, 5'd2, 5'd1, 5'd1, 5'd2);
        add_branch_case(3'd5, 5'd1, 5'd2, 5'd2, 5'd1);
        run_stream("branches", 64'h3000, 1'b0, 1'b0);
    endtask

    task automatic test_jumps();
        prog.push_back(enc_addi(12'd1, 5'd0, 5'd5));
        prog.push_back(enc_jal(21'd24, 5'd1));
        prog.push_back(enc_addi(12'd1, 5'd30, 5'd30));
        prog.push_back(enc_addi(12'd0, 5'd1, 5'd31));
        prog.push_back(enc_jal(21'(-12), 5'd0));
        prog.push_back(enc_jal(21'd8, 5'd7));
        prog.push_back(enc_addi(12'd2, 5'd0, 5'd6));
        prog.push_back(enc_jal(21'(-100), 5'd8));
        prog.push_back(enc_addi(12'd0, 5'd8, 5'd9));
        prog.push_back(enc_r(7'h00, 5'd8, 5'd8, 3'd0, 5'd9));
        run_stream("jumps", 64'h4000, 1'b0, 1'b0);
    endtask

    task automatic test_stalls();
        logic [63:0] kind;
        logic [63:0] rd;
        logic [63:0] rs1;
        logic [63:0] rs2;
        logic [63:0] imm;
        logic [2:0]  f3;
        logic [6:0]  f7;
        for (int i = 0; i < 60; i++) begin
            kind = rand_bits(3);
            rd   = rand_bits(5);
            rs1  = rand_bits(5);
            rs2  = rand_bits(5);
            imm  = rand_bits(20);
            case (kind[2:0])
                3'd3: prog.push_back(enc_addi(imm[11:0], rs1[4:0], rd[4:0]));
                3'd4: prog.push_back(enc_lui(imm[19:0], rd[4:0]));
                3'd5: begin
                    f3 = {imm[19], 1'b0, imm[18]};
                    prog.push_back(enc_br({imm[11:0], 1'b0}, rs2[4:0], rs1[4:0], f3));
                end
                3'd6: prog.push_back(enc_jal({imm[19:0], 1'b0}, rd[4:0]));
                default: begin
                    // ADD, SUB, SLL, SLT, XOR, SRL, OR, AND.
                    case (imm[2:0])
                        3'd0, 3'd1: f3 = 3'd0;
                        3'd2:       f3 = 3'd1;
                        3'd3:       f3 = 3'd2;
                        default:    f3 = imm[2:0];
                    endcase
                    f7 = (imm[2:0] == 3'd1) ? 7'h20 : 7'h00;
                    prog.push_back(enc_r(f7, rs2[4:0], rs1[4:0], f3, rd[4:0]));
                end
            endcase
        end
        run_stream("stalls", 64'h8000_0000, 1'b1, 1'b0);
    endtask

    //----------------------------------------
    // Main sequence.
    //----------------------------------------

    initial begin
        i_arst = 1'b1;
        issue  = '0;
        stall  = 1'b0;
        foreach (mregs[i]) begin
            mregs[i] = '0;
        end
        repeat (5) @(posedge i_clk);
        #1;
        i_arst = 1'b0;

        test_reset();
        test_alu_ops();
        test_dependencies();
        test_branches();
        test_jumps();
        test_stalls();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- datapath_top.f
common/dp_pkg.sv
execute/alu.sv
execute/branch_unit.sv
execute/execute_stage.sv
decode/register_file.sv
decode/decode_stage.sv
verilog/datapath_top.sv
tb/datapath_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the pipeline testbench with Verilator, runs it and checks the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module datapath_tb -Mdir obj_dir -f datapath_top.f

status=0
./obj_dir/Vdatapath_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "TEST FAILED" sim.log || [ "$status" -ne 0 ]; then
    echo "Simulation failed."
    exit 1
fi
echo "Simulation passed."
